/* list.f */
+incdir+hdl
hdl/ckpt_pkg.sv
hdl/grp_hdr_table.sv
hdl/ckpt_allocator.sv
hdl/ckpt_manager.sv
hdl/event_fifo.sv
hdl/ckpt_top.sv
verif/ckpt_tb.sv

/* verif/ckpt_tb.sv */
/* Testbench for ckpt_top. The host never writes a group while the manager works on it,
   so the model can predict every event in order */
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_tb
	import ckpt_pkg::*;
();

	// A few hundred bus accesses of about four cycles each, with a wide margin on top
	localparam int WATCHDOG_CYCLES = 20000;
	localparam int NG = `CKPT_NGROUP;
	localparam int NC = `CKPT_NCHECK;
	localparam int DW = `CKPT_WB_DW;
	localparam int HW = $bits(grp_hdr_t);

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`CKPT_WB_AW-1:0] wb_adr;
	logic [DW-1:0] wb_wdata;
	logic [DW-1:0] wb_rdata;
	logic wb_ack;
	logic restore;
	ckpt_ndx_t miss_cp;
	logic restore_done;
	logic ev_valid;
	ckpt_event_t ev_data;
	logic ev_ready;
	ckpt_cnt_t free_cnt;

	// Model of the table, the current checkpoint and the pool bitmap
	grp_hdr_t model_hdr [NG];
	ckpt_ndx_t model_cur;
	logic [NC-1:0] model_map;
	ckpt_event_t exp_q [$];

	int errors;
	int perm [NG];
	logic hold_ready;
	logic hold_check;

	ckpt_top u_dut (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
		.restore(restore), .miss_cp(miss_cp), .restore_done(restore_done),
		.ev_valid(ev_valid), .ev_data(ev_data), .ev_ready(ev_ready), .free_cnt(free_cnt)
	);

	always #50 clk = ~clk;

	// ==================================================
	// Reporting and model helpers
	// ==================================================

	task automatic report_failure(input string msg);
		errors++;
		$display("ERROR: %0t %s", $time, msg);
	endtask

	task automatic expect_equal(input string name, input int want, input int got);
		assert (want == got) else begin
			errors++;
			$display("[FAIL] %0t %s expected %0d got %0d", $time, name, want, got);
		end
	endtask

	// Drop every checkpoint that no valid stamped group and not the current index holds
	function automatic void release_unused();
		logic [NC-1:0] in_use;
		in_use = '0;
		for (int g = 0; g < NG; g++) begin
			if (model_hdr[g].v && model_hdr[g].cndxv) begin
				in_use[model_hdr[g].cndx] = 1'b1;
			end
		end
		in_use[model_cur] = 1'b1;
		model_map = model_map & in_use;
	endfunction

	function automatic int model_free_count();
		int n;
		n = 0;
		for (int c = 0; c < NC; c++) begin
			if (!model_map[c]) begin
				n++;
			end
		end
		return n;
	endfunction

	// A branch group takes the lowest free checkpoint, any other group takes the current one
	function automatic void predict_stamp(input int g);
		ckpt_event_t ev;
		int c;
		ev.kind = EV_SET;
		if (model_hdr[g].has_branch) begin
			c = 0;
			while (c < NC - 1 && model_map[c]) begin
				c++;
			end
			model_map[c] = 1'b1;
			model_cur = ckpt_ndx_t'(c);
			ev.kind = EV_NEW;
		end
		ev.grp = grp_ndx_t'(g);
		ev.cndx = model_cur;
		model_hdr[g].cndxv = 1'b1;
		model_hdr[g].cndx = model_cur;
		exp_q.push_back(ev);
		release_unused();
	endfunction

	function automatic void predict_restore(input int cp);
		ckpt_event_t ev;
		ev.kind = EV_RESTORE;
		ev.grp = '0;
		ev.cndx = ckpt_ndx_t'(cp);
		model_cur = ev.cndx;
		exp_q.push_back(ev);
		release_unused();
	endfunction

	// Pending header with a junk checkpoint field and a junk bit 7 that must read back as zero
	function automatic logic [DW-1:0] random_header(input logic v, input logic hb);
		grp_hdr_t h;
		h.v = v;
		h.has_branch = hb;
		h.cndxv = 1'b0;
		h.cndx = ckpt_ndx_t'($urandom);
		return DW'({1'($urandom), h});
	endfunction

	function automatic void shuffle_groups();
		int j;
		int tmp;
		for (int i = 0; i < NG; i++) begin
			perm[i] = i;
		end
		for (int i = NG - 1; i > 0; i--) begin
			j = $urandom % (i + 1);
			tmp = perm[i];
			perm[i] = perm[j];
			perm[j] = tmp;
		end
	endfunction

	// ==================================================
	// Wishbone host and sequencing tasks
	// ==================================================

	// The request is held until ack, then dropped on the edge that sees ack
	task automatic bus_access(input logic we, input int g, input logic [DW-1:0] wdata,
			output logic [DW-1:0] rdata);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= g[`CKPT_WB_AW-1:0];
		wb_wdata <= wdata;
		do begin
			@(posedge clk);
		end while (!wb_ack);
		rdata = wb_rdata;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic host_write(input int g, input logic [DW-1:0] data);
		logic [DW-1:0] ignored;
		bus_access(1'b1, g, data, ignored);
		model_hdr[g] = grp_hdr_t'(data[HW-1:0]);
		release_unused();
	endtask

	task automatic check_header(input int g);
		logic [DW-1:0] rd;
		bus_access(1'b0, g, '0, rd);
		expect_equal($sformatf("wb_rdata group %0d", g), {{(DW - HW){1'b0}}, model_hdr[g]}, rd);
	endtask

	// The pool bitmap follows a table change on the next edge
	task automatic check_free();
		@(posedge clk);
		expect_equal("free_cnt", model_free_count(), free_cnt);
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic wait_stamped(input int g);
		logic [DW-1:0] rd;
		grp_hdr_t h;
		h = '0;
		while (!h.cndxv) begin
			bus_access(1'b0, g, '0, rd);
			h = grp_hdr_t'(rd[HW-1:0]);
		end
	endtask

	task automatic stamp_group(input int g, input logic hb);
		host_write(g, random_header(1'b1, hb));
		predict_stamp(g);
		wait_drained();
		check_header(g);
		check_free();
	endtask

	task automatic wait_restore_done();
		do begin
			@(posedge clk);
		end while (restore);
	endtask

	// Consumer with random stalls, forced low while back-pressure is tested
	task automatic drive_ready();
		forever begin
			@(posedge clk);
			ev_ready <= hold_ready ? 1'b0 : (($urandom % 4) != 0);
		end
	endtask

	// The restore source lets go once it sees the done pulse
	task automatic drop_restore();
		forever begin
			@(posedge clk);
			if (restore_done) begin
				restore <= 1'b0;
			end
		end
	endtask

	// ==================================================
	// Event monitor and protocol checks
	// ==================================================

	always @(posedge clk) begin : event_monitor
		ckpt_event_t want;
		if (!rst && ev_valid && ev_ready) begin
			if (exp_q.size() == 0) begin
				report_failure("an event came out that the model did not expect");
			end
			else begin
				want = exp_q.pop_front();
				expect_equal("ev_data.kind", int'(want.kind), int'(ev_data.kind));
				expect_equal("ev_data.grp", want.grp, ev_data.grp);
				expect_equal("ev_data.cndx", want.cndx, ev_data.cndx);
			end
		end
	end

	ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else report_failure("wb_ack stayed high for more than one cycle");
	ack_follows_req: assert property (
		@(posedge clk) disable iff (rst) (wb_cyc && wb_stb && !wb_ack) |=> wb_ack
	) else report_failure("wb_ack did not follow the request in the next cycle");
	done_single: assert property (@(posedge clk) disable iff (rst) restore_done |=> !restore_done)
		else report_failure("restore_done lasted more than one cycle");
	done_needs_restore: assert property (@(posedge clk) disable iff (rst) restore_done |-> restore)
		else report_failure("restore_done rose without a held restore");
	done_blocked: assert property (@(posedge clk) disable iff (rst) hold_check |-> !restore_done)
		else report_failure("restore_done rose while the event FIFO was full");
	ev_held: assert property (
		@(posedge clk) disable iff (rst) (ev_valid && !ev_ready) |=> (ev_valid && $stable(ev_data))
	) else report_failure("a stalled event changed or vanished before it was taken");

	// ==================================================
	// Stimulus
	// ==================================================

	initial begin : main_flow
		int cp;
		int a_grp;
		int b_grp;
		int c_grp;
		clk = 1'b0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdata = '0;
		restore = 1'b0;
		miss_cp = '0;
		ev_ready = 1'b0;
		errors = 0;
		hold_ready = 1'b0;
		hold_check = 1'b0;
		for (int g = 0; g < NG; g++) begin
			model_hdr[g] = '0;
		end
		// Checkpoint 0 is current and allocated out of reset
		model_cur = '0;
		model_map = NC'(1);
		void'($urandom(15698));
		fork
			drive_ready();
			drop_restore();
		join_none
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		expect_equal("free_cnt", model_free_count(), free_cnt);
		expect_equal("ev_valid", 0, ev_valid);
		expect_equal("restore_done", 0, restore_done);

		// Invalid headers are never stamped and read back as written
		for (int g = 0; g < NG; g++) begin
			check_header(g);
			host_write(g, random_header(1'b0, 1'($urandom)));
			check_header(g);
		end

		// Plain stamp, then a branch followed by groups that inherit its checkpoint
		stamp_group($urandom % NG, 1'b0);
		shuffle_groups();
		stamp_group(perm[0], 1'b1);
		stamp_group(perm[1], 1'b0);
		stamp_group(perm[2], 1'b0);

		// Random patterns over the whole table, then clear groups to free checkpoints
		// The pool cannot run dry with fewer groups than checkpoints
		shuffle_groups();
		for (int i = 0; i < NG; i++) begin
			stamp_group(perm[i], 1'($urandom));
		end
		shuffle_groups();
		for (int i = 0; i < NG; i++) begin
			host_write(perm[i], '0);
			check_free();
		end

		// Restore makes the missed checkpoint current for the next plain stamp
		cp = $urandom % NC;
		predict_restore(cp);
		@(posedge clk);
		restore <= 1'b1;
		miss_cp <= ckpt_ndx_t'(cp);
		wait_restore_done();
		wait_drained();
		check_free();
		stamp_group($urandom % NG, 1'b0);

		// Fill the FIFO with ev_ready low, then park one group in the manager
		shuffle_groups();
		hold_ready <= 1'b1;
		for (int i = 0; i < `CKPT_FIFO_DEPTH; i++) begin
			host_write(perm[i], random_header(1'b1, 1'($urandom)));
			predict_stamp(perm[i]);
			wait_stamped(perm[i]);
		end
		a_grp = perm[4];
		b_grp = (perm[5] < perm[6]) ? perm[5] : perm[6];
		c_grp = (perm[5] < perm[6]) ? perm[6] : perm[5];
		host_write(a_grp, random_header(1'b1, 1'b0));
		hold_check = 1'b1;
		cp = $urandom % NC;
		@(posedge clk);
		restore <= 1'b1;
		miss_cp <= ckpt_ndx_t'(cp);
		host_write(b_grp, random_header(1'b1, 1'b0));
		host_write(c_grp, random_header(1'b1, 1'b0));
		check_header(a_grp);
		check_header(b_grp);
		check_header(c_grp);
		expect_equal("ev_valid", 1, ev_valid);
		// The oldest event still waits at the head of the stalled FIFO
		expect_equal("ev_data.kind", int'(exp_q[0].kind), int'(ev_data.kind));
		expect_equal("ev_data.grp", exp_q[0].grp, ev_data.grp);
		expect_equal("ev_data.cndx", exp_q[0].cndx, ev_data.cndx);

		// Parked group first, then the restore, then the rest highest group first
		predict_stamp(a_grp);
		predict_restore(cp);
		predict_stamp(c_grp);
		predict_stamp(b_grp);
		hold_check = 1'b0;
		hold_ready <= 1'b0;
		wait_restore_done();
		wait_drained();
		check_header(a_grp);
		check_header(b_grp);
		check_header(c_grp);
		check_free();
		// Nothing beyond the predicted events is left in the FIFO
		expect_equal("ev_valid", 0, ev_valid);

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end
		else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("ERROR: timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Errors: %0d", errors + 1);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* hdl/ckpt_top.sv */
/* Checkpoint manager top level. Restore must be held until restore_done and
   the host must follow Wishbone classic single accesses */
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_top
	import ckpt_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`CKPT_WB_AW-1:0] wb_adr,
	input logic [`CKPT_WB_DW-1:0] wb_wdata,
	output logic [`CKPT_WB_DW-1:0] wb_rdata,
	output logic wb_ack,
	input logic restore,
	input ckpt_ndx_t miss_cp,
	output logic restore_done,
	output logic ev_valid,
	output ckpt_event_t ev_data,
	input logic ev_ready,
	output ckpt_cnt_t free_cnt
);

	// ==================================================
	// Internal connections
	// ==================================================

	grp_hdr_t [`CKPT_NGROUP-1:0] headers;

	// Write-back from the manager into the table
	logic setcp;
	grp_ndx_t setcp_grp;
	ckpt_ndx_t cndx;

	// Allocator handshake
	logic alloc_req;
	ckpt_ndx_t avail_ckpt;
	logic stall;

	// Event path into the FIFO
	logic push;
	ckpt_event_t push_data;
	logic full;

	grp_hdr_table u_table (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
		.setcp(setcp), .setcp_grp(setcp_grp), .cndx(cndx), .headers(headers)
	);

	ckpt_manager u_manager (
		.clk(clk), .rst(rst), .headers(headers),
		.restore(restore), .miss_cp(miss_cp), .restore_done(restore_done),
		.avail_ckpt(avail_ckpt), .stall(stall), .alloc_req(alloc_req),
		.setcp(setcp), .setcp_grp(setcp_grp), .cndx(cndx),
		.full(full), .push(push), .push_data(push_data)
	);

	// The manager's cndx is the current checkpoint the allocator must keep
	ckpt_allocator u_allocator (
		.clk(clk), .rst(rst), .headers(headers), .cur_cndx(cndx),
		.alloc_req(alloc_req), .avail_ckpt(avail_ckpt), .stall(stall),
		.free_cnt(free_cnt)
	);

	event_fifo u_fifo (
		.clk(clk), .rst(rst), .push(push), .push_data(push_data), .full(full),
		.ev_valid(ev_valid), .ev_data(ev_data), .ev_ready(ev_ready)
	);

endmodule

/* hdl/event_fifo.sv */
/* Event FIFO with a valid/ready read side. A push while full is only taken if
   an entry leaves on the same edge */
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module event_fifo
	import ckpt_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic push,
	input ckpt_event_t push_data,
	output logic full,
	output logic ev_valid,
	output ckpt_event_t ev_data,
	input logic ev_ready
);

	localparam int DEPTH = `CKPT_FIFO_DEPTH;
	localparam int PW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	// Entry storage
	ckpt_event_t mem [DEPTH];

	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] wr_ptr;
	logic [CW-1:0] count;

	logic do_push;
	logic do_pop;

	// ==================================================
	// Handshake and status
	// ==================================================

	assign ev_valid = (count != '0);
	assign ev_data = mem[rd_ptr];
	assign full = (count == CW'(DEPTH));

	assign do_pop = ev_valid && ev_ready;
	assign do_push = push && (!full || do_pop);

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap at DEPTH so any depth works, not just a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			case ({do_push, do_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	count_in_range: assert property (
		@(posedge clk) disable iff (rst)
		count <= CW'(DEPTH)
	);

endmodule

/* hdl/ckpt_manager.sv */
/* Scanning checkpoint manager. Only one event is in flight at a time, so a new
   push waits one cycle after the last one even when the FIFO has room */
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_manager
	import ckpt_pkg::*;
(
	input logic clk,
	input logic rst,
	input grp_hdr_t [`CKPT_NGROUP-1:0] headers,
	input logic restore,
	input ckpt_ndx_t miss_cp,
	output logic restore_done,
	input ckpt_ndx_t avail_ckpt,
	input logic stall,
	output logic alloc_req,
	output logic setcp,
	output grp_ndx_t setcp_grp,
	output ckpt_ndx_t cndx,
	input logic full,
	output logic push,
	output ckpt_event_t push_data
);

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		ALLOC1 = 2'd1,
		ALLOC2 = 2'd2,
		SET = 2'd3
	} state_t;

	state_t state;

	// Highest numbered group that is valid but not yet stamped
	logic pick_found;
	grp_ndx_t pick_grp;
	logic pick_branch;

	logic can_push;
	logic restore_go;
	logic scan_go;
	logic take_alloc;
	logic take_set;

	// ==================================================
	// Pending group search
	// ==================================================

	always_comb begin
		pick_found = 1'b0;
		pick_grp = '0;
		pick_branch = 1'b0;
		// Later hits overwrite earlier ones so the top group wins
		for (int g = 0; g < `CKPT_NGROUP; g++) begin
			if (headers[g].v && !headers[g].cndxv) begin
				pick_found = 1'b1;
				pick_grp = grp_ndx_t'(g);
				pick_branch = headers[g].has_branch;
			end
		end
	end

	// A registered push still on its way would not show in full yet
	assign can_push = !full && !push;

	// The done pulse overlaps the held restore, so it must not count again
	assign restore_go = (state == IDLE) && restore && !restore_done && can_push;

	// While a stamp is being written back the table still shows the group pending
	assign scan_go = (state == IDLE) && !restore && !setcp && pick_found;

	assign take_alloc = (state == ALLOC2) && !stall && can_push;
	assign take_set = (state == SET) && can_push;

	// The allocator claims avail_ckpt on the same edge the manager latches it
	assign alloc_req = take_alloc;

	// ==================================================
	// Control FSM
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			setcp <= 1'b0;
			push <= 1'b0;
			restore_done <= 1'b0;
			cndx <= '0;
		end
		else begin
			setcp <= 1'b0;
			push <= 1'b0;
			restore_done <= 1'b0;
			case (state)
			IDLE: begin
				if (restore_go) begin
					// The missed checkpoint becomes current again
					cndx <= miss_cp;
					push <= 1'b1;
					restore_done <= 1'b1;
				end
				else if (scan_go) begin
					state <= pick_branch ? ALLOC1 : SET;
				end
			end
			ALLOC1: state <= ALLOC2;
			ALLOC2: begin
				// Sits here while the pool is empty or the FIFO has no room
				if (take_alloc) begin
					cndx <= avail_ckpt;
					setcp <= 1'b1;
					push <= 1'b1;
					state <= IDLE;
				end
			end
			SET: begin
				if (take_set) begin
					setcp <= 1'b1;
					push <= 1'b1;
					state <= IDLE;
				end
			end
			endcase
		end
	end

	// ==================================================
	// Group and event payload
	// ==================================================

	always_ff @(posedge clk) begin
		if (scan_go) begin
			setcp_grp <= pick_grp;
		end
		if (restore_go) begin
			push_data <= '{kind: EV_RESTORE, grp: '0, cndx: miss_cp};
		end
		else if (take_alloc) begin
			push_data <= '{kind: EV_NEW, grp: setcp_grp, cndx: avail_ckpt};
		end
		else if (take_set) begin
			push_data <= '{kind: EV_SET, grp: setcp_grp, cndx: cndx};
		end
	end

	// The in-flight rule keeps every push clear of a full FIFO
	push_not_full: assert property (
		@(posedge clk) disable iff (rst)
		push |-> !full
	);

endmodule

/* hdl/ckpt_allocator.sv */
/* Checkpoint pool bitmap. Frees run every cycle and only look at the table and
   the current index, so a checkpoint held elsewhere in the pipe is not protected */
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_allocator
	import ckpt_pkg::*;
(
	input logic clk,
	input logic rst,
	input grp_hdr_t [`CKPT_NGROUP-1:0] headers,
	input ckpt_ndx_t cur_cndx,
	input logic alloc_req,
	output ckpt_ndx_t avail_ckpt,
	output logic stall,
	output ckpt_cnt_t free_cnt
);

	// One bit per checkpoint, set while the checkpoint is allocated
	logic [`CKPT_NCHECK-1:0] alloc_map;

	// Checkpoints still referenced somewhere in the table or as current
	logic [`CKPT_NCHECK-1:0] in_use;

	// The bit claimed on this edge, if any
	logic [`CKPT_NCHECK-1:0] take_bit;

	// ==================================================
	// Reference scan
	// ==================================================

	always_comb begin
		in_use = '0;
		for (int g = 0; g < `CKPT_NGROUP; g++) begin
			// Only a valid group that was already stamped holds a checkpoint
			if (headers[g].v && headers[g].cndxv) begin
				in_use[headers[g].cndx] = 1'b1;
			end
		end
		in_use[cur_cndx] = 1'b1;
	end

	// ==================================================
	// Lowest free index and counters
	// ==================================================

	// Scan downward so the last hit is the lowest clear bit
	always_comb begin
		avail_ckpt = '0;
		for (int c = `CKPT_NCHECK - 1; c >= 0; c--) begin
			if (!alloc_map[c]) begin
				avail_ckpt = ckpt_ndx_t'(c);
			end
		end
	end

	// Pool is empty when every bit is set
	assign stall = &alloc_map;

	always_comb begin
		free_cnt = '0;
		for (int c = 0; c < `CKPT_NCHECK; c++) begin
			free_cnt = free_cnt + ckpt_cnt_t'(!alloc_map[c]);
		end
	end

	always_comb begin
		take_bit = '0;
		if (alloc_req && !stall) begin
			take_bit[avail_ckpt] = 1'b1;
		end
	end

	// Unreferenced checkpoints drop out, the new one is kept even though
	// nothing points at it until the next cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			// Checkpoint 0 is the current one out of reset
			alloc_map <= `CKPT_NCHECK'(1);
		end
		else begin
			alloc_map <= (alloc_map & in_use) | take_bit;
		end
	end

	// A request on an empty pool would land on a bit that is already set
	alloc_takes_free: assert property (
		@(posedge clk) disable iff (rst)
		alloc_req |-> !stall
	);

endmodule

/* hdl/grp_hdr_table.sv */
/* Group header table behind a Wishbone classic slave. Ack is registered, so every
   access takes two cycles and the host must hold its request until ack */
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module grp_hdr_table
	import ckpt_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`CKPT_WB_AW-1:0] wb_adr,
	input logic [`CKPT_WB_DW-1:0] wb_wdata,
	output logic [`CKPT_WB_DW-1:0] wb_rdata,
	output logic wb_ack,
	input logic setcp,
	input grp_ndx_t setcp_grp,
	input ckpt_ndx_t cndx,
	output grp_hdr_t [`CKPT_NGROUP-1:0] headers
);

	// Header registers, one per pipeline group
	grp_hdr_t [`CKPT_NGROUP-1:0] hdr_q;

	// A new bus request is one that has not been acknowledged yet
	logic req;
	logic host_wr;
	logic host_rd;

	// ==================================================
	// Wishbone request decode
	// ==================================================

	// Ack is high for one cycle only, so a held request is not taken twice
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign host_wr = req && wb_we;
	assign host_rd = req && !wb_we;

	// The manager and the allocator see the live table
	assign headers = hdr_q;

	// ==================================================
	// Header storage and write-back merge
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			hdr_q <= '0;
			wb_ack <= 1'b0;
		end
		else begin
			wb_ack <= req;
			for (int g = 0; g < `CKPT_NGROUP; g++) begin
				// A host write to the group being stamped overrides the stamp
				if (host_wr && wb_adr == `CKPT_WB_AW'(g)) begin
					hdr_q[g] <= grp_hdr_t'(wb_wdata[$bits(grp_hdr_t)-1:0]);
				end
				else if (setcp && setcp_grp == grp_ndx_t'(g)) begin
					// Only the checkpoint fields change on a stamp
					hdr_q[g].cndxv <= 1'b1;
					hdr_q[g].cndx <= cndx;
				end
			end
		end
	end

	// Read data is captured on the edge that raises ack and holds while ack is high
	// Unused upper bits of the bus word read back as zero
	always_ff @(posedge clk) begin
		if (host_rd) begin
			wb_rdata <= {{(`CKPT_WB_DW - $bits(grp_hdr_t)){1'b0}}, hdr_q[wb_adr]};
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	// Ack only answers a request that the host still holds
	ack_needs_req: assert property (
		@(posedge clk) disable iff (rst)
		wb_ack |-> (wb_cyc && wb_stb)
	);

endmodule

/* hdl/ckpt_pkg.sv */
/* Shared types for the checkpoint manager. Index widths follow the counts in the
   settings header, so both counts should be powers of two */
`include "ckpt_settings.svh"

package ckpt_pkg;

	// ==================================================
	// Index and count types
	// ==================================================

	typedef logic [$clog2(`CKPT_NCHECK)-1:0] ckpt_ndx_t;
	typedef logic [$clog2(`CKPT_NGROUP)-1:0] grp_ndx_t;

	// Wide enough to hold the full pool size, used for the free count
	typedef logic [$clog2(`CKPT_NCHECK + 1)-1:0] ckpt_cnt_t;

	// ==================================================
	// Group header and event records
	// ==================================================

	// One pipeline group header, packed into the low bits of a bus word
	typedef struct packed {
		logic v;
		logic has_branch;
		logic cndxv;
		ckpt_ndx_t cndx;
	} grp_hdr_t;

	// What the manager did with a checkpoint
	typedef enum logic [1:0] {
		EV_NEW = 2'd0,
		EV_SET = 2'd1,
		EV_RESTORE = 2'd2
	} ckpt_ev_kind_t;

	typedef struct packed {
		ckpt_ev_kind_t kind;
		grp_ndx_t grp;
		ckpt_ndx_t cndx;
	} ckpt_event_t;

endpackage

/* hdl/ckpt_settings.svh */
/* Sizes for the checkpoint manager. The group count must fit CKPT_WB_AW and
   a header word needs at least 7 data bits */
`ifndef CKPT_SETTINGS_SVH
`define CKPT_SETTINGS_SVH

// ==================================================
// Table and pool sizes
// ==================================================

// Number of pipeline group headers held in the table
`define CKPT_NGROUP 8

// Number of checkpoints in the free pool
`define CKPT_NCHECK 16

// Event FIFO entries between the manager and the consumer
`define CKPT_FIFO_DEPTH 4

// Wishbone sizes, one word per group header
`define CKPT_WB_AW 3
`define CKPT_WB_DW 8

`endif
